// File: common/game_pkg.sv
// shared game types
// game state, game mode, goal zone

package game_pkg;

    // round flow states
    // SHOOTER only keeps the encoding complete and is never entered
    typedef enum logic [2:0] {
        START   = 3'd0,
        KEEPER  = 3'd1,
        SHOOTER = 3'd2,
        WINNER  = 3'd3,
        LOSER   = 3'd4
    } g_state;

    // solo or multi player
    // multi holds the game at START for now
    typedef enum logic {
        SOLO  = 1'b0,
        MULTI = 1'b1
    } g_mode;

    // goal zones as seen from the keeper
    // code 2'b11 is left unused
    typedef enum logic [1:0] {
        ZONE_LEFT   = 2'd0,
        ZONE_CENTER = 2'd1,
        ZONE_RIGHT  = 2'd2
    } g_zone;

endpackage

// File: design/game_state_sel.sv
// game state and game mode registers
// next state logic for the solo round sequence
// mode latched from solo_enable only at START

module game_state_sel (
    input  logic               clk,
    input  logic               rst,
    input  logic               left_clicked,
    input  logic               right_clicked,
    input  logic               solo_enable,
    input  logic               is_scored,
    input  logic               round_done,
    output game_pkg::g_state   game_state
);

    game_pkg::g_state game_state_nxt;
    game_pkg::g_mode  game_mode;
    game_pkg::g_mode  game_mode_nxt;

    // state and mode registers
    always_ff @(posedge clk) begin
        if (rst) begin
            game_state <= game_pkg::START;
            game_mode  <= game_pkg::MULTI;
        end else begin
            game_state <= game_state_nxt;
            game_mode  <= game_mode_nxt;
        end
    end

    // mode only follows the switch on the start screen
    // so flipping it mid round changes nothing
    always_comb begin
        game_mode_nxt = game_mode;
        if (game_state == game_pkg::START) begin
            if (solo_enable) begin
                game_mode_nxt = game_pkg::SOLO;
            end else begin
                game_mode_nxt = game_pkg::MULTI;
            end
        end
    end

    // solo sequence START -> KEEPER -> WINNER/LOSER -> START
    always_comb begin
        game_state_nxt = game_pkg::START;
        if (game_mode == game_pkg::SOLO) begin
            case (game_state)
                game_pkg::START: begin
                    if (left_clicked) begin
                        game_state_nxt = game_pkg::KEEPER;
                    end
                end
                game_pkg::KEEPER: begin
                    // decision taken in the last keeper cycle
                    if (!round_done) begin
                        game_state_nxt = game_pkg::KEEPER;
                    end else if (is_scored) begin
                        game_state_nxt = game_pkg::LOSER;
                    end else begin
                        game_state_nxt = game_pkg::WINNER;
                    end
                end
                game_pkg::WINNER: begin
                    if (!right_clicked) begin
                        game_state_nxt = game_pkg::WINNER;
                    end
                end
                game_pkg::LOSER: begin
                    if (!right_clicked) begin
                        game_state_nxt = game_pkg::LOSER;
                    end
                end
                // SHOOTER and illegal codes fall back to start
                default: begin
                    game_state_nxt = game_pkg::START;
                end
            endcase
        end
        // multi mode parks at START
    end

    // shooter role is not built so the state must never appear
    a_no_shooter: assert property (
        @(posedge clk) disable iff (rst)
        game_state != game_pkg::SHOOTER
    ) else $error("game_state entered SHOOTER");

endmodule

// File: design/round_timer.sv
// keeper phase timer
// round_start on entry into KEEPER
// round_done in the last of ROUND_CYCLES keeper cycles

module round_timer #(
    parameter int ROUND_CYCLES = 8
) (
    input  logic             clk,
    input  logic             rst,
    input  game_pkg::g_state game_state,
    output logic             round_start,
    output logic             round_done
);

    // counter covers the cycles after the round_start cycle
    localparam int CNT_W = (ROUND_CYCLES > 2) ? $clog2(ROUND_CYCLES) : 1;
    localparam int LOAD  = (ROUND_CYCLES > 1) ? ROUND_CYCLES - 2 : 0;

    game_pkg::g_state   prev_state;
    logic [CNT_W-1:0]   cnt;
    logic               in_keeper;

    assign in_keeper   = (game_state == game_pkg::KEEPER);
    // edge detect on the state
    assign round_start = in_keeper && (prev_state != game_pkg::KEEPER);
    // single cycle round ends right away
    assign round_done  = in_keeper &&
                         (round_start ? (ROUND_CYCLES == 1) : (cnt == '0));

    always_ff @(posedge clk) begin
        if (rst) begin
            prev_state <= game_pkg::START;
            cnt        <= '0;
        end else begin
            prev_state <= game_state;
            if (round_start) begin
                cnt <= CNT_W'(LOAD);
            end else if (in_keeper && (cnt != '0)) begin
                // count down to the last keeper cycle
                cnt <= cnt - 1'b1;
            end
        end
    end

    // the controller must leave KEEPER right after round_done
    a_done_ends_round: assert property (
        @(posedge clk) disable iff (rst)
        round_done |-> in_keeper ##1 (game_state != game_pkg::KEEPER)
    ) else $error("round_done outside KEEPER or round not closed");

endmodule

// File: design/shot_sel.sv
// shot zone generator from an 8-bit LFSR folded to three zones
// dive latch for the first right click of a round
// goal decision from shot and dive

module shot_sel #(
    parameter logic [7:0] LFSR_SEED = 8'h5a
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             round_start,
    input  game_pkg::g_state game_state,
    input  logic             right_clicked,
    input  game_pkg::g_zone  mouse_zone,
    output game_pkg::g_zone  shot_zone,
    output logic             is_scored
);

    logic [7:0]      lfsr;
    logic            lfsr_fb;
    game_pkg::g_zone zone_fold;
    game_pkg::g_zone dive_zone;
    logic            dived;

    // maximal length taps 8 6 5 4
    assign lfsr_fb = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];

    // free running and never zero from a nonzero seed
    always_ff @(posedge clk) begin
        if (rst) begin
            lfsr <= LFSR_SEED;
        end else begin
            lfsr <= {lfsr[6:0], lfsr_fb};
        end
    end

    // modulo 3 keeps the unused code out
    assign zone_fold = game_pkg::g_zone'(2'(lfsr % 8'd3));

    // shot zone picked once per round
    always_ff @(posedge clk) begin
        if (rst) begin
            shot_zone <= game_pkg::ZONE_CENTER;
        end else if (round_start) begin
            shot_zone <= zone_fold;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dived <= 1'b0;
        end else if (round_start) begin
            // a click on the very first keeper cycle still counts
            dived <= right_clicked;
        end else if ((game_state == game_pkg::KEEPER) && right_clicked) begin
            dived <= 1'b1;
        end
    end

    // dive target from the first click of the round
    always_ff @(posedge clk) begin
        if (round_start || ((game_state == game_pkg::KEEPER) && right_clicked && !dived)) begin
            dive_zone <= mouse_zone;
        end
    end

    // goal unless the keeper went the right way
    assign is_scored = !(dived && (dive_zone == shot_zone));

    // shot zone must never hold the spare code
    a_zone_legal: assert property (
        @(posedge clk) disable iff (rst)
        shot_zone != game_pkg::g_zone'(2'b11)
    ) else $error("shot_zone holds unused code");

endmodule

// File: design/score_keeper.sv
// win and loss counters
// updated on round_done and saturating at all ones

module score_keeper #(
    parameter int SCORE_W = 4
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               round_done,
    input  logic               is_scored,
    output logic [SCORE_W-1:0] wins,
    output logic [SCORE_W-1:0] losses
);

    logic wins_full;
    logic losses_full;

    // counters stop at their max
    assign wins_full   = &wins;
    assign losses_full = &losses;

    always_ff @(posedge clk) begin
        if (rst) begin
            wins   <= '0;
            losses <= '0;
        end else if (round_done) begin
            // goal means the keeper lost
            if (is_scored) begin
                if (!losses_full) begin
                    losses <= losses + 1'b1;
                end
            end else begin
                if (!wins_full) begin
                    wins <= wins + 1'b1;
                end
            end
        end
    end

endmodule

// File: design/penalty_top.sv
// round controller top
// state controller, round timer, shot logic, score counters

module penalty_top #(
    parameter int         ROUND_CYCLES = 8,
    parameter int         SCORE_W      = 4,
    parameter logic [7:0] LFSR_SEED    = 8'h5a
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               left_clicked,
    input  logic               right_clicked,
    input  logic               solo_enable,
    input  game_pkg::g_zone    mouse_zone,
    output game_pkg::g_state   game_state,
    output game_pkg::g_zone    shot_zone,
    output logic [SCORE_W-1:0] wins,
    output logic [SCORE_W-1:0] losses
);

    // pulses between blocks
    logic round_start;
    logic round_done;
    logic is_scored;

    game_state_sel game_state_sel_i (
        .clk           (clk),
        .rst           (rst),
        .left_clicked  (left_clicked),
        .right_clicked (right_clicked),
        .solo_enable   (solo_enable),
        .is_scored     (is_scored),
        .round_done    (round_done),
        .game_state    (game_state)
    );

    round_timer #(
        .ROUND_CYCLES (ROUND_CYCLES)
    ) round_timer_i (
        .clk         (clk),
        .rst         (rst),
        .game_state  (game_state),
        .round_start (round_start),
        .round_done  (round_done)
    );

    shot_sel #(
        .LFSR_SEED (LFSR_SEED)
    ) shot_sel_i (
        .clk           (clk),
        .rst           (rst),
        .round_start   (round_start),
        .game_state    (game_state),
        .right_clicked (right_clicked),
        .mouse_zone    (mouse_zone),
        .shot_zone     (shot_zone),
        .is_scored     (is_scored)
    );

    score_keeper #(
        .SCORE_W (SCORE_W)
    ) score_keeper_i (
        .clk        (clk),
        .rst        (rst),
        .round_done (round_done),
        .is_scored  (is_scored),
        .wins       (wins),
        .losses     (losses)
    );

endmodule

// File: sim/penalty_tb.sv
// testbench for the penalty round controller
// clock, reset, click stimulus, reference model
// concurrent assertions against the model

module penalty_tb;

    localparam int ROUND_CYCLES = 8;
    localparam int SCORE_W      = 4;
    localparam logic [SCORE_W-1:0] SCORE_MAX = {SCORE_W{1'b1}};
    // about 47 rounds of up to 20 cycles each and twice that as margin
    localparam int MAX_CYCLES   = 2000;

    logic clk = 1'b0;
    logic rst;
    logic left_clicked;
    logic right_clicked;
    logic solo_enable;
    game_pkg::g_zone    mouse_zone;
    game_pkg::g_state   game_state;
    game_pkg::g_zone    shot_zone;
    logic [SCORE_W-1:0] wins;
    logic [SCORE_W-1:0] losses;

    // reference model state
    game_pkg::g_state   exp_state;
    game_pkg::g_mode    exp_mode;
    game_pkg::g_zone    m_dive;
    game_pkg::g_zone    obs_shot;
    logic               m_dived;
    int                 keep_cnt;
    logic [SCORE_W-1:0] exp_wins;
    logic [SCORE_W-1:0] exp_losses;

    integer seed = 32'hfd4da166;
    int     cycle_cnt = 0;
    int     err_cnt = 0;

    always #50 clk = ~clk;

    penalty_top #(
        .ROUND_CYCLES (ROUND_CYCLES),
        .SCORE_W      (SCORE_W)
    ) penalty_top_i (
        .clk           (clk),
        .rst           (rst),
        .left_clicked  (left_clicked),
        .right_clicked (right_clicked),
        .solo_enable   (solo_enable),
        .mouse_zone    (mouse_zone),
        .game_state    (game_state),
        .shot_zone     (shot_zone),
        .wins          (wins),
        .losses        (losses)
    );

    task automatic value_fail(input string name, input int actual, input int expected);
        err_cnt = err_cnt + 1;
        $display("CHECK FAILED t=%0t %s dut=%0d exp=%0d", $time, name, actual, expected);
        $display("ERRORS FOUND");
        $fatal(1, "mismatch on %s", name);
    endtask

    // model of the round rules
    always @(posedge clk) begin
        if (rst) begin
            exp_state  <= game_pkg::START;
            exp_mode   <= game_pkg::MULTI;
            keep_cnt   <= 0;
            m_dived    <= 1'b0;
            exp_wins   <= '0;
            exp_losses <= '0;
        end else begin
            // mode follows the switch only at START
            if (exp_state == game_pkg::START) begin
                exp_mode <= solo_enable ? game_pkg::SOLO : game_pkg::MULTI;
            end
            if (exp_mode == game_pkg::MULTI) begin
                exp_state <= game_pkg::START;
            end else begin
                case (exp_state)
                    game_pkg::START: begin
                        if (left_clicked) begin
                            exp_state <= game_pkg::KEEPER;
                            keep_cnt  <= 1;
                            m_dived   <= 1'b0;
                        end
                    end
                    game_pkg::KEEPER: begin
                        // first dive of the round only
                        if (right_clicked && !m_dived) begin
                            m_dived <= 1'b1;
                            m_dive  <= mouse_zone;
                        end
                        // shot valid from the second keeper cycle
                        if (keep_cnt == 2) begin
                            obs_shot <= shot_zone;
                        end
                        if (keep_cnt < ROUND_CYCLES) begin
                            keep_cnt <= keep_cnt + 1;
                        end else if (m_dived && (m_dive == obs_shot)) begin
                            exp_state <= game_pkg::WINNER;
                            if (exp_wins != SCORE_MAX) begin
                                exp_wins <= exp_wins + 1'b1;
                            end
                        end else begin
                            exp_state <= game_pkg::LOSER;
                            if (exp_losses != SCORE_MAX) begin
                                exp_losses <= exp_losses + 1'b1;
                            end
                        end
                    end
                    game_pkg::WINNER, game_pkg::LOSER: begin
                        if (right_clicked) begin
                            exp_state <= game_pkg::START;
                        end
                    end
                    default: begin
                        exp_state <= game_pkg::START;
                    end
                endcase
            end
        end
    end

    a_state: assert property (@(posedge clk) disable iff (rst) game_state == exp_state)
        else value_fail("game_state", $sampled(game_state), $sampled(exp_state));
    a_wins: assert property (@(posedge clk) disable iff (rst) wins == exp_wins)
        else value_fail("wins", $sampled(wins), $sampled(exp_wins));
    a_losses: assert property (@(posedge clk) disable iff (rst) losses == exp_losses)
        else value_fail("losses", $sampled(losses), $sampled(exp_losses));
    // shot stays put for the rest of the round and the result screen
    a_shot: assert property (@(posedge clk) disable iff (rst)
        ((exp_state == game_pkg::KEEPER) && (keep_cnt > 2)) ||
        (exp_state == game_pkg::WINNER) || (exp_state == game_pkg::LOSER)
        |-> shot_zone == obs_shot)
        else value_fail("shot_zone", $sampled(shot_zone), $sampled(obs_shot));

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("ERRORS FOUND");
            $fatal(1, "timeout");
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    // one solo round where kind 0 is no dive, 1 a dive on the shot and 2 a wrong dive
    task automatic play_round(input int kind, input bit drop_solo);
        game_pkg::g_zone shot;
        int gap;
        int z;
        solo_enable = 1'b1;
        next_cycle();
        left_clicked = 1'b1;
        next_cycle();
        left_clicked = 1'b0;
        while (game_state != game_pkg::KEEPER) begin
            next_cycle();
        end
        next_cycle();
        shot = shot_zone;
        // switch flipped mid round must not matter
        if (drop_solo) begin
            solo_enable = 1'b0;
        end
        gap = $random(seed) & 3;
        repeat (gap) next_cycle();
        if (kind != 0) begin
            z = (kind == 1) ? int'(shot) : (int'(shot) + 1 + ($random(seed) & 1)) % 3;
            mouse_zone    = game_pkg::g_zone'(z[1:0]);
            right_clicked = 1'b1;
            next_cycle();
            right_clicked = 1'b0;
        end
        while (game_state == game_pkg::KEEPER) begin
            next_cycle();
        end
        // result screen holds until the right click
        gap = $random(seed) & 3;
        repeat (gap) next_cycle();
        right_clicked = 1'b1;
        next_cycle();
        right_clicked = 1'b0;
    endtask

    initial begin
        rst           = 1'b1;
        left_clicked  = 1'b0;
        right_clicked = 1'b0;
        solo_enable   = 1'b0;
        mouse_zone    = game_pkg::ZONE_LEFT;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        // multi mode ignores clicks
        repeat (3) begin
            next_cycle();
            left_clicked = 1'b1;
            next_cycle();
            left_clicked = 1'b0;
        end
        play_round(0, 1'b0);
        play_round(1, 1'b0);
        play_round(2, 1'b0);
        play_round(1, 1'b1);
        play_round(0, 1'b1);
        repeat (8) play_round(($random(seed) & 3) % 3, 1'b0);
        // past saturation on both counters
        repeat (17) play_round(1, 1'b0);
        repeat (17) play_round(2, 1'b0);
        next_cycle();
        a_wins_sat: assert (wins == SCORE_MAX)
            else value_fail("wins", wins, SCORE_MAX);
        a_losses_sat: assert (losses == SCORE_MAX)
            else value_fail("losses", losses, SCORE_MAX);
        if (err_cnt == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            $display("ERRORS FOUND");
            $fatal(1, "checks failed");
        end
    end

endmodule

// File: sim.f
common/game_pkg.sv
design/game_state_sel.sv
design/round_timer.sv
design/shot_sel.sv
design/score_keeper.sv
design/penalty_top.sv
sim/penalty_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the penalty round controller testbench with verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module penalty_tb -f sim.f -o penalty_sim \
    && ./obj_dir/penalty_sim | tee /dev/stderr | grep -qx "NO ERRORS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
